//--- flist.f
hdl/playseq_pkg.sv
hdl/playseq_memorias.sv
hdl/playseq_fluxo_dados.sv
hdl/playseq_unidade_controle.sv
hdl/playseq.sv
verif/playseq_asserts.sv
verif/playseq_tb.sv

//--- Makefile
# Verilator build and run for the PlaySeq testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = playseq_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/playseq_tb.sv
//----------------------------------------------------------------------
// PlaySeq testbench: clock and reset, seeded random games, model
// of sequences and outcomes, check task, watchdog, run result
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module playseq_tb;

    logic                          clock;
    logic                          reset;
    logic                          iniciar;
    playseq_pkg::playseq_cfg_t     cfg;
    logic [3:0]                    botoes;
    logic [3:0]                    leds;
    playseq_pkg::playseq_status_t  status;

    integer semente;
    int     num_jogos = 20;
    bit     resultado_dado;            // set once a final message is printed

    playseq i_playseq (
        .clock   (clock),
        .reset   (reset),
        .iniciar (iniciar),
        .cfg     (cfg),
        .botoes  (botoes),
        .leds    (leds),
        .status  (status)
    );

    bind playseq playseq_asserts i_asserts (
        .clock  (clock),
        .reset  (reset),
        .leds   (leds),
        .status (status)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //------------------------------------------------------------------
    // reporting and checks
    //------------------------------------------------------------------
    task automatic fail_run(input string motivo);
        resultado_dado = 1'b1;
        $display("%s", motivo);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string nome, input logic [31:0] esperado,
                               input logic [31:0] obtido);
        if (obtido !== esperado) begin
            fail_run($sformatf("Mismatch at %0t ns: %s expected %0h, got %0h",
                               $time, nome, esperado, obtido));
        end
    endtask

    // pronto, preview, jogando, ganhou, perdeu, timeout
    function automatic logic [5:0] status_flags();
        return {status.pronto, status.preview, status.jogando,
                status.ganhou, status.perdeu, status.timeout};
    endfunction

    function automatic int random_below(input int n);
        integer r;
        r = $random(semente);
        return int'($unsigned(r) % n);
    endfunction

    //------------------------------------------------------------------
    // model of the stored sequences
    //------------------------------------------------------------------
    function automatic logic [3:0] expected_entry(input logic [1:0] sel, input int pos);
        int tabela;
        tabela = (sel == 2'd3) ? 0 : int'(sel);     // selection 3 reuses table 0
        return playseq_pkg::SEQ_TABELAS[tabela][pos];
    endfunction

    // another one-hot code, rotated away from the right one
    function automatic logic [3:0] wrong_code(input logic [3:0] certo, input int giro);
        logic [3:0] codigo;
        codigo = certo;
        for (int k = 0; k < giro; k++) begin
            codigo = {codigo[2:0], codigo[3]};
        end
        return codigo;
    endfunction

    //------------------------------------------------------------------
    // stimulus and response tasks
    //------------------------------------------------------------------
    task automatic start_game(input logic [1:0] nivel, input logic [1:0] sel);
        @(posedge clock);
        #1;
        iniciar     = 1'b1;
        cfg.nivel   = nivel;
        cfg.seletor = sel;
        @(posedge clock);
        #1;
        iniciar = 1'b0;
        cfg     = playseq_pkg::playseq_cfg_t'(4'(random_below(16)));  // must be ignored now
    endtask

    // watches one preview up to the rise of jogando
    task automatic collect_preview(input logic [1:0] sel, input int l, input int ate_led);
        int idx;
        int n_runs;
        int run_len;
        int escuro;
        int primeiro;
        int limite;
        bit em_jogo;
        idx      = 0;
        n_runs   = 0;
        run_len  = 0;
        escuro   = 0;
        primeiro = 0;
        em_jogo  = 1'b0;
        limite   = l * (playseq_pkg::LED_ON + playseq_pkg::LED_OFF + 2) + 10;
        while (!em_jogo) begin
            @(negedge clock);
            idx++;
            if (idx > limite) begin
                fail_run($sformatf("Preview of length %0d never handed over to play", l));
            end
            if (status.jogando) begin
                em_jogo = 1'b1;
            end else begin
                check_value("status.preview", 32'd1, 32'(status.preview));
                if (leds != 4'b0000) begin
                    if (n_runs >= l) begin
                        fail_run("Preview lit more entries than the round length");
                    end
                    if (run_len == 0 && n_runs == 0) begin
                        primeiro = idx;
                    end
                    check_value("status.rodada", 32'(l), 32'(status.rodada));
                    check_value($sformatf("leds (entry %0d)", n_runs),
                                32'(expected_entry(sel, n_runs)), 32'(leds));
                    run_len++;
                    escuro = 0;
                end else begin
                    if (run_len != 0) begin
                        check_value("leds lit cycles", playseq_pkg::LED_ON, run_len);
                        n_runs++;
                        run_len = 0;
                    end
                    escuro++;
                end
            end
        end
        check_value("leds entries shown", l, n_runs);
        check_value("leds dark cycles before play", playseq_pkg::LED_OFF, escuro);
        if (ate_led != 0) begin
            check_value("leds cycles from iniciar", ate_led, primeiro);
        end
    endtask

    // held 2 cycles, released 2 cycles
    // a start strobe with a random cfg rides along and must be ignored in play
    task automatic press_button(input logic [3:0] codigo);
        botoes  = codigo;
        iniciar = 1'b1;
        cfg     = playseq_pkg::playseq_cfg_t'(4'(random_below(16)));
        @(negedge clock);
        check_value("status.jogando", 32'd1, 32'(status.jogando));
        check_value("leds", 32'(codigo), 32'(leds));
        @(posedge clock);
        #1;
        iniciar = 1'b0;
        @(negedge clock);
        check_value("leds", 32'(codigo), 32'(leds));
        @(posedge clock);
        #1;
        botoes = 4'b0000;
        repeat (2) @(posedge clock);
        #1;
    endtask

    task automatic wait_outcome();
        int n;
        n = 0;
        @(negedge clock);
        while (!(status.ganhou || status.perdeu)) begin
            n++;
            if (n > 8) begin
                fail_run("No game result appeared after the last press");
            end
            @(negedge clock);
        end
    endtask

    // starts at the negedge where jogando rose
    task automatic wait_timeout();
        int n;
        n = 0;
        while (!status.perdeu) begin
            @(negedge clock);
            n++;
            if (n > playseq_pkg::TIMEOUT_JOGADA + 3) begin
                fail_run($sformatf("No timeout within %0d cycles of idle play", n));
            end
        end
        if (n < playseq_pkg::TIMEOUT_JOGADA) begin
            fail_run($sformatf("Timeout came after only %0d cycles of idle play", n));
        end
    endtask

    // finished state must ignore buttons until the next iniciar
    task automatic hold_finished(input logic [5:0] flags_fim, input int rod);
        repeat (6) begin
            @(posedge clock);
            #1;
            botoes = 4'(random_below(16));
            @(negedge clock);
            check_value("status flags", 32'(flags_fim), 32'(status_flags()));
            check_value("status.rodada", 32'(rod), 32'(status.rodada));
            check_value("leds", 32'd0, 32'(leds));
        end
        @(posedge clock);
        #1;
        botoes = 4'b0000;
    endtask

    // modo 0 wins, 1 presses a wrong button, 2 lets the play timer run out
    task automatic run_game(input int modo);
        logic [1:0] nivel;
        logic [1:0] sel;
        logic [3:0] certo;
        logic [5:0] flags_fim;
        int         l_ini;
        int         l_fim;
        int         rod_erro;
        int         pos_erro;
        int         rod_atual;
        bit         fim;
        nivel     = 2'(random_below(4));
        sel       = 2'(random_below(4));
        l_ini     = int'(playseq_pkg::RODADA_INICIAL[nivel]);
        l_fim     = int'(playseq_pkg::RODADA_FINAL[nivel]);
        rod_erro  = l_ini + random_below(l_fim - l_ini + 1);
        pos_erro  = 0;
        rod_atual = l_ini;
        fim       = 1'b0;
        start_game(nivel, sel);
        for (int l = l_ini; (l <= l_fim) && !fim; l++) begin
            rod_atual = l;
            collect_preview(sel, l, (l == l_ini) ? 3 : 0);   // 3 cycles to first lit LED
            if (modo == 2 && l == rod_erro) begin
                wait_timeout();
                fim = 1'b1;
            end else begin
                if (modo == 1 && l == rod_erro) begin
                    pos_erro = random_below(l);
                end
                @(posedge clock);
                #1;
                for (int i = 0; (i < l) && !fim; i++) begin
                    certo = expected_entry(sel, i);
                    if (modo == 1 && l == rod_erro && i == pos_erro) begin
                        press_button(wrong_code(certo, 1 + random_below(3)));
                        fim = 1'b1;
                    end else begin
                        press_button(certo);
                    end
                end
            end
        end
        if (modo != 2) begin
            wait_outcome();
        end
        case (modo)
            0:       flags_fim = 6'b000100;
            1:       flags_fim = 6'b000010;
            default: flags_fim = 6'b000011;
        endcase
        check_value("status flags", 32'(flags_fim), 32'(status_flags()));
        check_value("status.rodada", 32'(rod_atual), 32'(status.rodada));
        hold_finished(flags_fim, rod_atual);
    endtask

    //------------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------------
    initial begin : main
        semente        = 59;
        resultado_dado = 1'b0;
        reset          = 1'b1;
        iniciar        = 1'b0;
        cfg            = '0;
        botoes         = 4'b0000;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("status flags", 32'(6'b100000), 32'(status_flags()));
        check_value("leds", 32'd0, 32'(leds));
        check_value("status.rodada", 32'd0, 32'(status.rodada));
        for (int g = 0; g < num_jogos; g++) begin
            run_game(g % 3);
        end
        resultado_dado = 1'b1;
        $display("TESTS PASSED");
        $finish;
    end

    // worst game is 12 rounds of a 12-entry preview, play and a timeout
    initial begin : watchdog
        int ciclos_rodada;
        int limite;
        ciclos_rodada = 12 * (playseq_pkg::LED_ON + playseq_pkg::LED_OFF + 2) + 4
                      + 12 * 4 + playseq_pkg::TIMEOUT_JOGADA;
        limite = num_jogos * (12 * ciclos_rodada + 30) + 100;
        repeat (limite) @(posedge clock);
        fail_run($sformatf("Watchdog expired after %0d cycles, the run hung", limite));
    end

    // run stopped elsewhere, e.g. by a failing assertion
    final begin
        if (!resultado_dado) begin
            $display("Run stopped before the testbench reached a result");
            $display("TESTS FAILED");
        end
    end

endmodule

`default_nettype wire

//--- verif/playseq_asserts.sv
//----------------------------------------------------------------------
// concurrent assertions on the PlaySeq status flags, preview LEDs
// and round length, bound to the top level
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module playseq_asserts (
    input wire                              clock,
    input wire                              reset,
    input wire [3:0]                        leds,
    input wire playseq_pkg::playseq_status_t status
);

    // one game phase at a time
    a_one_phase: assert property (@(posedge clock) disable iff (reset)
        $onehot0({status.pronto, status.preview, status.jogando, status.ganhou, status.perdeu}))
        else $error("more than one game phase flag is set");

    a_timeout_lost: assert property (@(posedge clock) disable iff (reset)
        status.timeout |-> status.perdeu)
        else $error("timeout flag set without perdeu");

    // preview shows a single entry or nothing
    a_preview_leds: assert property (@(posedge clock) disable iff (reset)
        status.preview |-> $onehot0(leds))
        else $error("more than one LED lit during the preview");

    a_rodada_max: assert property (@(posedge clock) disable iff (reset)
        status.rodada <= 4'd12)      // longest final length
        else $error("round length above the largest final length");

endmodule

`default_nettype wire

//--- hdl/playseq.sv
//----------------------------------------------------------------------
// PlaySeq top level, control unit plus datapath
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module playseq (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             iniciar,     // one-cycle start strobe
    input  wire playseq_pkg::playseq_cfg_t  cfg,
    input  wire [3:0]                       botoes,
    output logic [3:0]                      leds,
    output playseq_pkg::playseq_status_t    status
);

    playseq_pkg::playseq_ctrl_t          ctrl;
    playseq_pkg::playseq_cond_t          cond;
    logic [5:0]                          flags;
    logic [playseq_pkg::LARGURA_END-1:0] rodada;

    playseq_unidade_controle i_unidade_controle (
        .clock   (clock),
        .reset   (reset),
        .iniciar (iniciar),
        .cond    (cond),
        .ctrl    (ctrl),
        .flags   (flags)
    );

    playseq_fluxo_dados i_fluxo_dados (
        .clock   (clock),
        .reset   (reset),
        .iniciar (iniciar),
        .cfg     (cfg),
        .botoes  (botoes),
        .ctrl    (ctrl),
        .cond    (cond),
        .leds    (leds),
        .rodada  (rodada)
    );

    // flag order follows the status struct
    assign status.pronto  = flags[5];
    assign status.preview = flags[4];
    assign status.jogando = flags[3];
    assign status.ganhou  = flags[2];
    assign status.perdeu  = flags[1];
    assign status.timeout = flags[0];
    assign status.rodada  = rodada;

endmodule

`default_nettype wire

//--- hdl/playseq_unidade_controle.sv
//----------------------------------------------------------------------
// PlaySeq control unit: game FSM, ctrl decode and status flags
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module playseq_unidade_controle (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             iniciar,
    input  wire playseq_pkg::playseq_cond_t cond,
    output playseq_pkg::playseq_ctrl_t      ctrl,
    output logic [5:0]                      flags    // pronto .. timeout, msb first
);

    typedef enum logic [3:0] {
        est_ocioso,
        est_inicio,
        est_busca,             // memory fetch
        est_mostra,            // entry lit
        est_intervalo,         // entry dark
        est_proximo,
        est_espera,            // wait for press
        est_registra,
        est_compara,
        est_avanca,
        est_proxima_rodada,
        est_ganhou,
        est_perdeu
    } estado_t;

    estado_t estado, prox_estado;
    logic    timeout_r;

    //------------------------------------------------------------------
    // state register and timeout flag
    //------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            estado <= est_ocioso;
        end else begin
            estado <= prox_estado;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            timeout_r <= 1'b0;
        end else if (estado == est_inicio) begin
            timeout_r <= 1'b0;
        end else if (estado == est_espera && cond.fim_timeout) begin
            timeout_r <= 1'b1;
        end
    end

    //------------------------------------------------------------------
    // next state
    //------------------------------------------------------------------
    always_comb begin
        prox_estado = estado;
        case (estado)
            est_ocioso, est_ganhou, est_perdeu: begin
                if (iniciar) prox_estado = est_inicio;
            end
            est_inicio:    prox_estado = est_busca;
            est_busca:     prox_estado = est_mostra;
            est_mostra: begin
                if (cond.fim_led_on) prox_estado = est_intervalo;
            end
            est_intervalo: begin
                if (cond.fim_led_off) begin
                    prox_estado = cond.fim_end ? est_espera : est_proximo;
                end
            end
            est_proximo:   prox_estado = est_busca;
            est_espera: begin
                if (cond.fim_timeout)     prox_estado = est_perdeu;
                else if (cond.tem_jogada) prox_estado = est_registra;
            end
            est_registra:  prox_estado = est_compara;
            est_compara: begin
                if (!cond.igual)       prox_estado = est_perdeu;
                else if (!cond.fim_end) prox_estado = est_avanca;
                else if (cond.fim_seq)  prox_estado = est_ganhou;
                else                    prox_estado = est_proxima_rodada;
            end
            est_avanca:         prox_estado = est_espera;
            est_proxima_rodada: prox_estado = est_busca;
            default:            prox_estado = est_ocioso;
        endcase
    end

    //------------------------------------------------------------------
    // datapath control
    //------------------------------------------------------------------
    always_comb begin
        ctrl = '0;
        case (estado)
            est_inicio: begin
                ctrl.zera_end     = 1'b1;
                ctrl.carrega_rod  = 1'b1;
                ctrl.fase_preview = 1'b1;
            end
            est_busca: begin
                ctrl.zera_led     = 1'b1;
                ctrl.fase_preview = 1'b1;
            end
            est_mostra: begin
                ctrl.conta_led    = 1'b1;
                ctrl.fase_preview = 1'b1;
                ctrl.liga_leds    = 1'b1;
            end
            est_intervalo: begin
                ctrl.conta_led    = 1'b1;
                ctrl.zera_tmr     = 1'b1;    // play timer starts fresh
                ctrl.fase_preview = 1'b1;
                // rewind to the first entry when play begins
                ctrl.zera_end     = cond.fim_led_off & cond.fim_end;
            end
            est_proximo: begin
                ctrl.conta_end    = 1'b1;
                ctrl.fase_preview = 1'b1;
            end
            est_espera: begin
                ctrl.conta_tmr    = 1'b1;
                ctrl.registra_bot = 1'b1;    // value kept is the one at the pulse
                ctrl.liga_leds    = 1'b1;
            end
            est_registra: begin
                ctrl.zera_tmr     = 1'b1;
                ctrl.liga_leds    = 1'b1;
            end
            est_compara: ctrl.liga_leds = 1'b1;
            est_avanca: begin
                ctrl.conta_end    = 1'b1;
                ctrl.liga_leds    = 1'b1;
            end
            est_proxima_rodada: begin
                ctrl.conta_rod    = 1'b1;
                ctrl.zera_end     = 1'b1;
                ctrl.fase_preview = 1'b1;
            end
            default: ctrl = '0;              // idle, won, lost stay quiet
        endcase
    end

    //------------------------------------------------------------------
    // status flags
    //------------------------------------------------------------------
    always_comb begin
        flags    = '0;
        flags[5] = (estado == est_ocioso);
        flags[4] = estado inside {est_inicio, est_busca, est_mostra, est_intervalo,
                                  est_proximo, est_proxima_rodada};
        flags[3] = estado inside {est_espera, est_registra, est_compara, est_avanca};
        flags[2] = (estado == est_ganhou);
        flags[1] = (estado == est_perdeu);
        flags[0] = timeout_r & (estado == est_perdeu);
    end

endmodule

`default_nettype wire

//--- hdl/playseq_fluxo_dados.sv
//----------------------------------------------------------------------
// PlaySeq datapath: config register, address and length counters,
// button register and comparator, press edge detector, timers, LED mux
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module playseq_fluxo_dados (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire                                 iniciar,
    input  wire playseq_pkg::playseq_cfg_t      cfg,
    input  wire [3:0]                           botoes,
    input  wire playseq_pkg::playseq_ctrl_t     ctrl,
    output playseq_pkg::playseq_cond_t          cond,
    output logic [3:0]                          leds,
    output logic [playseq_pkg::LARGURA_END-1:0] rodada
);

    playseq_pkg::playseq_cfg_t               cfg_r;
    logic [playseq_pkg::LARGURA_END-1:0]     endereco;
    logic [playseq_pkg::LARGURA_END-1:0]     rodada_r;
    logic [3:0]                              dado;
    logic [3:0]                              botoes_r;
    logic                                    botoes_ant;
    logic [playseq_pkg::LARGURA_TMR-1:0]     tmr_jogada;
    logic [playseq_pkg::LARGURA_LED-1:0]     tmr_led;

    //------------------------------------------------------------------
    // configuration, taken only while the game is not running
    //------------------------------------------------------------------
    // all ctrl bits are low only in idle, won and lost
    always_ff @(posedge clock) begin
        if (reset) begin
            cfg_r <= '0;
        end else if (iniciar && (ctrl == '0)) begin
            cfg_r <= cfg;
        end
    end

    //------------------------------------------------------------------
    // counters
    //------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            endereco <= '0;
        end else if (ctrl.zera_end) begin
            endereco <= '0;
        end else if (ctrl.conta_end) begin
            endereco <= endereco + 1'b1;
        end
    end

    // round length, starts from the level's table
    always_ff @(posedge clock) begin
        if (reset) begin
            rodada_r <= '0;
        end else if (ctrl.carrega_rod) begin
            rodada_r <= playseq_pkg::RODADA_INICIAL[cfg_r.nivel];
        end else if (ctrl.conta_rod) begin
            rodada_r <= rodada_r + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tmr_jogada <= '0;
        end else if (ctrl.zera_tmr) begin
            tmr_jogada <= '0;
        end else if (ctrl.conta_tmr) begin
            tmr_jogada <= tmr_jogada + 1'b1;
        end
    end

    // runs through the lit part and then the dark part of one entry
    always_ff @(posedge clock) begin
        if (reset) begin
            tmr_led <= '0;
        end else if (ctrl.zera_led) begin
            tmr_led <= '0;
        end else if (ctrl.conta_led) begin
            tmr_led <= tmr_led + 1'b1;
        end
    end

    //------------------------------------------------------------------
    // buttons
    //------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (ctrl.registra_bot) begin
            botoes_r <= botoes;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            botoes_ant <= 1'b0;
        end else begin
            botoes_ant <= |botoes;
        end
    end

    playseq_memorias i_memorias (
        .clock    (clock),
        .endereco (endereco),
        .seletor  (cfg_r.seletor),
        .dado     (dado)
    );

    //------------------------------------------------------------------
    // conditions to the control unit
    //------------------------------------------------------------------
    assign cond.igual       = (botoes_r == dado);
    assign cond.fim_end     = (endereco == rodada_r - 1'b1);
    assign cond.fim_seq     = (rodada_r == playseq_pkg::RODADA_FINAL[cfg_r.nivel]);
    assign cond.tem_jogada  = (|botoes) & ~botoes_ant;     // rising edge of any button
    assign cond.fim_timeout = (tmr_jogada == playseq_pkg::FIM_TMR);
    assign cond.fim_led_on  = (tmr_led == playseq_pkg::FIM_LED_ON);
    assign cond.fim_led_off = (tmr_led == playseq_pkg::FIM_LED_OFF);

    // memory word in the preview, buttons in play, dark otherwise
    always_comb begin
        if (!ctrl.liga_leds) begin
            leds = 4'b0000;
        end else if (ctrl.fase_preview) begin
            leds = dado;
        end else begin
            leds = botoes;
        end
    end

    assign rodada = rodada_r;

endmodule

`default_nettype wire

//--- hdl/playseq_memorias.sv
//----------------------------------------------------------------------
// three read-only sequence memories with registered output
// and the selection mux in front of the datapath
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module playseq_memorias (
    input  wire                                 clock,
    input  wire [playseq_pkg::LARGURA_END-1:0]  endereco,
    input  wire [1:0]                           seletor,
    output logic [3:0]                          dado
);

    logic [3:0] dado_mem [3];                  // one read port per table

    //------------------------------------------------------------------
    // synchronous read, data valid the cycle after the address
    //------------------------------------------------------------------
    always_ff @(posedge clock) begin
        for (int m = 0; m < 3; m++) begin
            dado_mem[m] <= playseq_pkg::SEQ_TABELAS[m][endereco];
        end
    end

    //------------------------------------------------------------------
    // sequence selection
    //------------------------------------------------------------------
    always_comb begin
        case (seletor)
            2'd1:    dado = dado_mem[1];
            2'd2:    dado = dado_mem[2];
            default: dado = dado_mem[0];   // 0 and 3 share the first table
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/playseq_pkg.sv
//----------------------------------------------------------------------
// PlaySeq game constants, level length tables, the three fixed
// colour sequences and the structs shared by control unit and datapath
//----------------------------------------------------------------------
`default_nettype none

package playseq_pkg;

    localparam int LARGURA_END = 4;            // address and length width

    // preview and play timing, in clock cycles
    localparam int LED_ON         = 4;
    localparam int LED_OFF        = 2;
    localparam int TIMEOUT_JOGADA = 40;

    localparam int LARGURA_LED = $clog2(LED_ON + LED_OFF);
    localparam int LARGURA_TMR = $clog2(TIMEOUT_JOGADA);

    // terminal counts of the two timers
    localparam logic [LARGURA_LED-1:0] FIM_LED_ON  = LARGURA_LED'(LED_ON - 1);
    localparam logic [LARGURA_LED-1:0] FIM_LED_OFF = LARGURA_LED'(LED_ON + LED_OFF - 1);
    localparam logic [LARGURA_TMR-1:0] FIM_TMR     = LARGURA_TMR'(TIMEOUT_JOGADA - 1);

    // start and final lengths, indexed by level
    localparam logic [LARGURA_END-1:0] RODADA_INICIAL [4] = '{4'd3, 4'd5, 4'd8, 4'd8};
    localparam logic [LARGURA_END-1:0] RODADA_FINAL   [4] = '{4'd5, 4'd8, 4'd12, 4'd12};

    // one-hot button codes, one row per stored sequence
    localparam logic [3:0] SEQ_TABELAS [3][16] = '{
        '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0001, 4'b0100, 4'b0010, 4'b1000,
          4'b0100, 4'b0001, 4'b1000, 4'b0010, 4'b0010, 4'b0100, 4'b0001, 4'b1000},
        '{4'b1000, 4'b1000, 4'b0001, 4'b0100, 4'b0010, 4'b0010, 4'b1000, 4'b0001,
          4'b0100, 4'b0100, 4'b0010, 4'b0001, 4'b1000, 4'b0010, 4'b0100, 4'b0001},
        '{4'b0100, 4'b0001, 4'b0001, 4'b0010, 4'b1000, 4'b0100, 4'b1000, 4'b0010,
          4'b0001, 4'b1000, 4'b0100, 4'b0100, 4'b0010, 4'b0001, 4'b1000, 4'b0010}
    };

    typedef struct packed {
        logic [1:0] nivel;                     // difficulty level
        logic [1:0] seletor;                   // sequence choice, 3 reuses 0
    } playseq_cfg_t;

    typedef struct packed {
        logic zera_end;                        // address counter
        logic conta_end;
        logic carrega_rod;                     // length counter
        logic conta_rod;
        logic zera_tmr;                        // play timer
        logic conta_tmr;
        logic zera_led;                        // led timer
        logic conta_led;
        logic registra_bot;                    // button register enable
        logic fase_preview;                    // led source is memory
        logic liga_leds;
    } playseq_ctrl_t;

    typedef struct packed {
        logic igual;
        logic fim_end;
        logic fim_seq;
        logic tem_jogada;
        logic fim_timeout;
        logic fim_led_on;
        logic fim_led_off;
    } playseq_cond_t;

    typedef struct packed {
        logic                   pronto;
        logic                   preview;
        logic                   jogando;
        logic                   ganhou;
        logic                   perdeu;
        logic                   timeout;
        logic [LARGURA_END-1:0] rodada;
    } playseq_status_t;

endpackage

`default_nettype wire
